// File: source/rvPkg.sv
// RV32I subset only (no shifts, byte/half access, JALR, AUIPC, CSRs or traps); 256-word memory
`default_nettype none

package rvPkg;

    localparam int xLen        = 32;
    localparam int memDepth    = 256;
    localparam int memAddrBits = 8;   // byte address bits 9:2

    // ****************************************
    // opcodes
    // ****************************************
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opSystem = 7'b1110011;

    // operand selects
    localparam logic       aSelPc   = 1'b0;
    localparam logic       aSelRs1  = 1'b1;
    localparam logic [1:0] bSelRs2  = 2'd0;
    localparam logic [1:0] bSelFour = 2'd1;
    localparam logic [1:0] bSelImm  = 2'd2;

    typedef enum logic [2:0] {aluAdd, aluSub, aluSlt, aluXor, aluOr, aluAnd} aluOpT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSelT;

    // ****************************************
    // instruction word views
    // ****************************************
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHigh7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLow5;
            logic [6:0] opcode;
        } sbType;   // S and B formats share the split
    } instrU;

    typedef struct packed {
        logic       pcWrite;
        logic       pcFromAluOut;
        logic       addrFromAluOut;
        logic       memWrite;
        logic       irWrite;
        logic       regWrite;
        logic       wbFromMem;
        logic       wbFromPc;
        logic       aluOutWrite;
        logic       aSel;
        logic [1:0] bSel;
        immSelT     immSel;
        aluOpT      aluOp;
    } ctrlT;

    typedef struct packed {
        logic            valid;
        logic [xLen-1:0] addr;   // byte address
        logic [xLen-1:0] data;
    } storeEventT;

endpackage

`default_nettype wire

// File: source/unifiedMemory.sv
// word access only, addr bits 1:0 and above bit 9 ignored; loader must stay idle while the core runs
`timescale 1ns/100ps
`default_nettype none

module unifiedMemory import rvPkg::*; (
    input  wire                     clk,
    input  logic                    loadEn,
    input  logic [memAddrBits-1:0]  loadAddr,
    input  logic [xLen-1:0]         loadData,
    input  logic [xLen-1:0]         addr,
    input  logic [xLen-1:0]         writeData,
    input  logic                    memWrite,
    output logic [xLen-1:0]         readData,
    output storeEventT              storeEvent
);

    logic [xLen-1:0]        mem [memDepth];
    logic [memAddrBits-1:0] wordIdx;

    assign wordIdx = addr[memAddrBits+1:2];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;   // testbench loader
        end else if (memWrite) begin
            mem[wordIdx] <= writeData;
        end
    end

    assign readData = mem[wordIdx];   // async read

    // every core write is reported in the same cycle
    assign storeEvent = '{valid: memWrite, addr: addr, data: writeData};

    // loader and core must never compete for the array
    loaderCoreExcl: assert property (@(posedge clk) !(loadEn && memWrite));

endmodule

`default_nettype wire

// File: source/regFile.sv
// 32 x 32-bit registers, x0 hard-wired to zero; reads are combinational, no write-to-read bypass
`timescale 1ns/100ps
`default_nettype none

module regFile import rvPkg::*; (
    input  wire              clk,
    input  logic             regWrite,
    input  logic [4:0]       rdAddr,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    input  logic [xLen-1:0]  rdData,
    output logic [xLen-1:0]  rs1Data,
    output logic [xLen-1:0]  rs2Data
);

    logic [xLen-1:0] regs [1:31];   // no storage for x0

    always_ff @(posedge clk) begin
        if (regWrite && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    // a value written to x1..x31 reads back on the next cycle
    writeReadBack: assert property (@(posedge clk)
        (regWrite && rdAddr != 5'd0) |=>
            (rs1Addr != $past(rdAddr) || rs1Data == $past(rdData)));

endmodule

`default_nettype wire

// File: source/alu.sv
// purely combinational; no shifts and no overflow or carry flags
`timescale 1ns/100ps
`default_nettype none

module alu import rvPkg::*; (
    input  logic [xLen-1:0] a,
    input  logic [xLen-1:0] b,
    input  aluOpT           aluOp,
    output logic [xLen-1:0] result,
    output logic            zero
);

    always_comb begin
        unique case (aluOp)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluSlt: begin
                result = ($signed(a) < $signed(b)) ? xLen'(1) : '0;   // signed compare
            end
            aluXor: begin
                result = a ^ b;
            end
            aluOr: begin
                result = a | b;
            end
            aluAnd: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);   // equality test after aluSub

endmodule

`default_nettype wire

// File: source/controlFsm.sv
// unknown opcodes retire as no-ops; EBREAK is matched on opcode alone and halts until reset
`timescale 1ns/100ps
`default_nettype none

module controlFsm import rvPkg::*; (
    input  wire    clk,
    input  wire    arstN,
    input  logic   run,
    input  instrU  instr,
    input  logic   zero,
    output ctrlT   ctrl,
    output logic   halted
);

    typedef enum logic [2:0] {
        sFetch, sDecode, sExecute, sMemory, sWriteback, sHalt
    } stateT;

    stateT      state;
    stateT      nextState;
    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr.rType.opcode;
    assign funct3 = instr.rType.funct3;

    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic subtract);
        case (f3)
            3'b000:  return subtract ? aluSub : aluAdd;
            3'b010:  return aluSlt;
            3'b100:  return aluXor;
            3'b110:  return aluOr;
            3'b111:  return aluAnd;
            default: return aluAdd;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    // ****************************************
    // outputs and next state per state
    // ****************************************
    always_comb begin
        ctrl      = '0;
        nextState = state;
        unique case (state)
            sFetch: begin
                if (run) begin
                    ctrl.irWrite = 1'b1;
                    ctrl.pcWrite = 1'b1;   // pc + 4 straight from the ALU
                    ctrl.aSel    = aSelPc;
                    ctrl.bSel    = bSelFour;
                    ctrl.aluOp   = aluAdd;
                    nextState    = sDecode;
                end
            end
            sDecode: begin
                ctrl.aSel        = aSelPc;   // branch / jump target ahead of time
                ctrl.bSel        = bSelImm;
                ctrl.immSel      = (opcode == opJal) ? immJ : immB;
                ctrl.aluOp       = aluAdd;
                ctrl.aluOutWrite = 1'b1;
                nextState        = (opcode == opSystem) ? sHalt : sExecute;
            end
            sExecute: begin
                ctrl.aSel  = aSelRs1;
                ctrl.bSel  = bSelImm;
                ctrl.aluOp = aluAdd;
                nextState  = sFetch;
                case (opcode)
                    opLui: begin
                        ctrl.immSel      = immU;   // operand A is zero here
                        ctrl.aluOutWrite = 1'b1;
                        nextState        = sWriteback;
                    end
                    opOpImm: begin
                        ctrl.immSel      = immI;
                        ctrl.aluOp       = aluFromFunct3(funct3, 1'b0);
                        ctrl.aluOutWrite = 1'b1;
                        nextState        = sWriteback;
                    end
                    opOp: begin
                        ctrl.bSel        = bSelRs2;
                        ctrl.aluOp       = aluFromFunct3(funct3, instr.rType.funct7[5]);
                        ctrl.aluOutWrite = 1'b1;
                        nextState        = sWriteback;
                    end
                    opLoad, opStore: begin
                        ctrl.immSel      = (opcode == opStore) ? immS : immI;
                        ctrl.aluOutWrite = 1'b1;   // effective address
                        nextState        = sMemory;
                    end
                    opBranch: begin
                        ctrl.bSel         = bSelRs2;
                        ctrl.aluOp        = aluSub;
                        ctrl.pcFromAluOut = 1'b1;
                        ctrl.pcWrite      = funct3[0] ? !zero : zero;   // bne / beq
                    end
                    opJal: begin
                        ctrl.pcFromAluOut = 1'b1;
                        ctrl.pcWrite      = 1'b1;
                        ctrl.regWrite     = 1'b1;
                        ctrl.wbFromPc     = 1'b1;   // link = old pc + 4
                    end
                    default: begin
                        nextState = sFetch;
                    end
                endcase
            end
            sMemory: begin
                ctrl.addrFromAluOut = 1'b1;
                ctrl.memWrite       = (opcode == opStore);
                nextState           = (opcode == opLoad) ? sWriteback : sFetch;
            end
            sWriteback: begin
                ctrl.regWrite  = 1'b1;
                ctrl.wbFromMem = (opcode == opLoad);
                nextState      = sFetch;
            end
            sHalt: begin
                nextState = sHalt;
            end
            default: begin
                nextState = sFetch;
            end
        endcase
    end

    assign halted = (state == sHalt);

    irMemExcl: assert property (@(posedge clk) disable iff (!arstN)
        !(ctrl.irWrite && ctrl.memWrite));

    haltSticky: assert property (@(posedge clk) disable iff (!arstN)
        state == sHalt |=> state == sHalt);

endmodule

`default_nettype wire

// File: source/datapath.sv
// pc resets to 0; holding registers carry no reset and are valid only once fetch has run
`timescale 1ns/100ps
`default_nettype none

module datapath import rvPkg::*; (
    input  wire              clk,
    input  wire              arstN,
    input  ctrlT             ctrl,
    input  logic [xLen-1:0]  readData,
    input  logic [xLen-1:0]  aluResult,
    input  logic [xLen-1:0]  rs1Data,
    input  logic [xLen-1:0]  rs2Data,
    output logic [xLen-1:0]  memAddr,
    output logic [xLen-1:0]  writeData,
    output logic [xLen-1:0]  aluA,
    output logic [xLen-1:0]  aluB,
    output instrU            instr,
    output logic [xLen-1:0]  rdData
);

    logic [xLen-1:0] pc;
    logic [xLen-1:0] instrPc;   // pc of the instruction in flight
    logic [xLen-1:0] pcPlus4;
    logic [xLen-1:0] mdr;
    logic [xLen-1:0] rs1Q;
    logic [xLen-1:0] rs2Q;
    logic [xLen-1:0] aluOut;
    logic [xLen-1:0] imm;
    logic [xLen-1:0] pcBase;
    logic            decodeQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= '0;
            decodeQ <= 1'b0;
        end else begin
            decodeQ <= ctrl.irWrite;   // next cycle is decode
            if (ctrl.pcWrite) begin
                pc <= ctrl.pcFromAluOut ? aluOut : aluResult;
            end
        end
    end

    // ****************************************
    // holding registers
    // ****************************************
    always_ff @(posedge clk) begin
        mdr  <= readData;
        rs1Q <= (instr.rType.opcode == opLui) ? '0 : rs1Data;   // lui has no rs1
        rs2Q <= rs2Data;
        if (ctrl.irWrite) begin
            instr   <= readData;
            instrPc <= pc;
        end
        if (decodeQ) begin
            pcPlus4 <= pc;   // pc already advanced in fetch
        end
        if (ctrl.aluOutWrite) begin
            aluOut <= aluResult;
        end
    end

    always_comb begin
        unique case (ctrl.immSel)
            immI: imm = {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
            immS: imm = {{20{instr.sbType.immHigh7[6]}}, instr.sbType.immHigh7,
                         instr.sbType.immLow5};
            immB: imm = {{19{instr.sbType.immHigh7[6]}}, instr.sbType.immHigh7[6],
                         instr.sbType.immLow5[0], instr.sbType.immHigh7[5:0],
                         instr.sbType.immLow5[4:1], 1'b0};
            immU: imm = {instr.rType.funct7, instr.rType.rs2, instr.rType.rs1,
                         instr.rType.funct3, 12'b0};
            immJ: imm = {{11{instr.rType.funct7[6]}}, instr.rType.funct7[6],
                         instr.rType.rs1, instr.rType.funct3, instr.rType.rs2[0],
                         instr.rType.funct7[5:0], instr.rType.rs2[4:1], 1'b0};
            default: imm = '0;
        endcase
    end

    // fetch works on the live pc, later cycles on the fetched one
    assign pcBase = ctrl.irWrite ? pc : instrPc;

    assign aluA = (ctrl.aSel == aSelRs1) ? rs1Q : pcBase;

    always_comb begin
        case (ctrl.bSel)
            bSelRs2:  aluB = rs2Q;
            bSelFour: aluB = xLen'(4);
            bSelImm:  aluB = imm;
            default:  aluB = '0;
        endcase
    end

    assign memAddr   = ctrl.addrFromAluOut ? aluOut : pc;
    assign writeData = rs2Q;
    assign rdData    = ctrl.wbFromMem ? mdr : (ctrl.wbFromPc ? pcPlus4 : aluOut);

endmodule

`default_nettype wire

// File: source/multiCycleCpu.sv
// load memory only while run is low; memory contents survive reset
`timescale 1ns/100ps
`default_nettype none

module multiCycleCpu import rvPkg::*; (
    input  wire                     clk,
    input  wire                     arstN,
    input  logic                    run,
    input  logic                    loadEn,
    input  logic [memAddrBits-1:0]  loadAddr,
    input  logic [xLen-1:0]         loadData,
    output storeEventT              storeEvent,
    output logic                    halted
);

    ctrlT            ctrl;
    instrU           instr;
    logic            zero;
    logic [xLen-1:0] readData;
    logic [xLen-1:0] memAddr;
    logic [xLen-1:0] writeData;
    logic [xLen-1:0] aluA;
    logic [xLen-1:0] aluB;
    logic [xLen-1:0] aluResult;
    logic [xLen-1:0] rs1Data;
    logic [xLen-1:0] rs2Data;
    logic [xLen-1:0] rdData;

    unifiedMemory memInst (
        .clk(clk), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .addr(memAddr), .writeData(writeData), .memWrite(ctrl.memWrite),
        .readData(readData), .storeEvent(storeEvent)
    );

    controlFsm ctrlInst (
        .clk(clk), .arstN(arstN), .run(run), .instr(instr), .zero(zero),
        .ctrl(ctrl), .halted(halted)
    );

    datapath dpInst (
        .clk(clk), .arstN(arstN), .ctrl(ctrl), .readData(readData),
        .aluResult(aluResult), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .memAddr(memAddr), .writeData(writeData), .aluA(aluA), .aluB(aluB),
        .instr(instr), .rdData(rdData)
    );

    regFile rfInst (
        .clk(clk), .regWrite(ctrl.regWrite), .rdAddr(instr.rType.rd),
        .rs1Addr(instr.rType.rs1), .rs2Addr(instr.rType.rs2), .rdData(rdData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    alu aluInst (
        .a(aluA), .b(aluB), .aluOp(ctrl.aluOp), .result(aluResult), .zero(zero)
    );

endmodule

`default_nettype wire

// File: sim/multiCycleCpuTb.sv
// directed tests; register file is never reset, so each program writes every register it reads
`timescale 1ns/100ps
`default_nettype none

module multiCycleCpuTb import rvPkg::*; ();

    localparam logic [31:0] ebreakWord = 32'h00100073;

    logic                   clk;
    logic                   arstN;
    logic                   run;
    logic                   loadEn;
    logic [memAddrBits-1:0] loadAddr;
    logic [xLen-1:0]        loadData;
    storeEventT             storeEvent;
    logic                   halted;

    logic [31:0] prog [$];
    storeEventT  stores [$];
    logic [31:0] val [32];   // expected register values
    int          errors;
    int          checks;
    integer      seed;

    multiCycleCpu DUT (
        .clk(clk), .arstN(arstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .storeEvent(storeEvent), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // store monitor
    always @(negedge clk) begin
        if (arstN && storeEvent.valid) begin
            stores.push_back(storeEvent);
        end
    end

    // ****************************************
    // RV32I encoders
    // ****************************************
    function automatic logic [31:0] opImm(input logic [2:0] f3, input logic [31:0] rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opOpImm};
    endfunction

    function automatic logic [31:0] opReg(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [31:0] rd, rs1, rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opOp};
    endfunction

    function automatic logic [31:0] lui(input logic [31:0] rd, imm20);
        return {imm20[19:0], rd[4:0], opLui};
    endfunction

    function automatic logic [31:0] lw(input logic [31:0] rd, rs1, imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], opLoad};
    endfunction

    function automatic logic [31:0] sw(input logic [31:0] rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [31:0] rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] jal(input logic [31:0] rd, off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opJal};
    endfunction

    // ****************************************
    // checking and sequencing
    // ****************************************
    task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, what, actual, expected);
        end
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data, input string what);
        storeEventT ev;
        if (stores.size() == 0) begin
            errors++;
            $display("no store event arrived for %s", what);
        end else begin
            ev = stores.pop_front();
            check(ev.addr, addr, {what, " address"});
            check(ev.data, data, {what, " data"});
        end
    endtask

    task automatic expectNoMoreStores(input string what);
        if (stores.size() != 0) begin
            errors++;
            $display("%0d unexpected store events in %s", stores.size(), what);
            stores.delete();
        end
    endtask

    task automatic resetCore();
        @(posedge clk);
        run   <= 1'b0;
        arstN <= 1'b0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
    endtask

    task automatic loadProgram();
        foreach (prog[i]) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= memAddrBits'(i);
            loadData <= prog[i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    task automatic waitHalt(input int maxCycles);
        int n;
        n = 0;
        while (!halted && n < maxCycles) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            $display("timeout: core did not halt within %0d cycles", maxCycles);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic runProgram(input int maxCycles);
        resetCore();
        loadProgram();
        stores.delete();
        @(posedge clk);
        run <= 1'b1;
        waitHalt(maxCycles);
    endtask

    // ****************************************
    // tests
    // ****************************************
    task automatic testArith();
        int r;
        prog.delete();
        prog.push_back(lui(1, 32'h12345));
        prog.push_back(opImm(3'b000, 1, 1, 32'h678));   // addi
        prog.push_back(opImm(3'b000, 2, 0, -5));
        prog.push_back(opImm(3'b000, 3, 0, 7));
        prog.push_back(opImm(3'b010, 4, 2, -3));        // slti
        prog.push_back(opImm(3'b010, 5, 3, -3));
        prog.push_back(opImm(3'b100, 6, 1, 32'h0ff));   // xori
        prog.push_back(opImm(3'b110, 7, 3, 32'h700));   // ori
        prog.push_back(opImm(3'b111, 8, 1, -16));       // andi
        prog.push_back(opReg(7'h00, 3'b000, 9, 1, 2));  // add
        prog.push_back(opReg(7'h20, 3'b000, 10, 3, 2)); // sub
        prog.push_back(opReg(7'h00, 3'b010, 11, 2, 3)); // slt
        prog.push_back(opReg(7'h00, 3'b010, 12, 3, 2));
        prog.push_back(opReg(7'h00, 3'b100, 13, 1, 2)); // xor
        prog.push_back(opReg(7'h00, 3'b110, 14, 2, 3)); // or
        prog.push_back(opReg(7'h00, 3'b111, 15, 1, 2)); // and
        for (r = 1; r < 16; r++) begin
            prog.push_back(sw(r, 0, 32'h200 + 4 * r));
        end
        prog.push_back(ebreakWord);
        val[1]  = {20'h12345, 12'h000} + 32'h678;
        val[2]  = 32'd0 - 32'd5;
        val[3]  = 32'd7;
        val[4]  = ($signed(val[2]) < -3) ? 32'd1 : 32'd0;
        val[5]  = ($signed(val[3]) < -3) ? 32'd1 : 32'd0;
        val[6]  = val[1] ^ 32'h0000_00ff;
        val[7]  = val[3] | 32'h0000_0700;
        val[8]  = val[1] & 32'hffff_fff0;   // 0xff0 sign-extended
        val[9]  = val[1] + val[2];
        val[10] = val[3] - val[2];
        val[11] = ($signed(val[2]) < $signed(val[3])) ? 32'd1 : 32'd0;
        val[12] = ($signed(val[3]) < $signed(val[2])) ? 32'd1 : 32'd0;
        val[13] = val[1] ^ val[2];
        val[14] = val[2] | val[3];
        val[15] = val[1] & val[2];
        runProgram(1000);
        for (r = 1; r < 16; r++) begin
            expectStore(32'h200 + 4 * r, val[r], $sformatf("arith x%0d", r));
        end
        expectNoMoreStores("arith");
    endtask

    task automatic testLoadStore();
        logic [31:0] big;
        big = {20'habcde, 12'h000} - 32'd1;
        prog.delete();
        prog.push_back(opImm(3'b000, 1, 0, 32'h123));
        prog.push_back(lui(2, 32'habcde));
        prog.push_back(opImm(3'b000, 2, 2, -1));
        prog.push_back(sw(1, 0, 32'h300));
        prog.push_back(sw(2, 0, 32'h304));
        prog.push_back(opImm(3'b000, 3, 0, 32'h310));
        prog.push_back(lw(4, 3, -16));    // negative offsets
        prog.push_back(lw(5, 3, -12));
        prog.push_back(opImm(3'b000, 6, 0, 32'h2f0));
        prog.push_back(lw(7, 6, 32'h14));
        prog.push_back(sw(4, 3, 0));
        prog.push_back(sw(5, 3, 4));
        prog.push_back(sw(7, 6, 8));
        prog.push_back(ebreakWord);
        runProgram(1000);
        expectStore(32'h300, 32'h123, "first store");
        expectStore(32'h304, big, "second store");
        expectStore(32'h310, 32'h123, "reload of x4");
        expectStore(32'h314, big, "reload of x5");
        expectStore(32'h2f8, big, "reload of x7");
        expectNoMoreStores("load/store");
    endtask

    task automatic testBranches();
        logic [31:0] sum;
        int i;
        sum = 0;
        for (i = 1; i <= 10; i++) begin
            sum = sum + i;
        end
        prog.delete();
        prog.push_back(opImm(3'b000, 1, 0, 0));
        prog.push_back(opImm(3'b000, 2, 0, 1));
        prog.push_back(opImm(3'b000, 3, 0, 11));
        prog.push_back(opReg(7'h00, 3'b000, 1, 1, 2));   // loop body at 12
        prog.push_back(opImm(3'b000, 2, 2, 1));
        prog.push_back(branch(3'b001, 2, 3, -8));       // bne back to 12
        prog.push_back(sw(1, 0, 32'h200));
        prog.push_back(opImm(3'b000, 4, 0, 32'h0aa));
        prog.push_back(branch(3'b000, 1, 3, 8));        // beq not taken
        prog.push_back(sw(4, 0, 32'h204));
        prog.push_back(branch(3'b000, 2, 3, 8));        // beq taken
        prog.push_back(sw(4, 0, 32'h208));
        prog.push_back(opImm(3'b000, 5, 0, 32'h0bb));
        prog.push_back(sw(5, 0, 32'h20c));
        prog.push_back(ebreakWord);
        runProgram(2000);
        expectStore(32'h200, sum, "loop sum");
        expectStore(32'h204, 32'h0aa, "beq not taken path");
        expectStore(32'h20c, 32'h0bb, "beq taken target");
        expectNoMoreStores("branches");
    endtask

    task automatic testJal();
        prog.delete();
        prog.push_back(opImm(3'b000, 1, 0, 1));
        prog.push_back(jal(5, 8));        // at byte 4, skips one word
        prog.push_back(sw(1, 0, 32'h200));
        prog.push_back(sw(5, 0, 32'h204));
        prog.push_back(ebreakWord);
        runProgram(500);
        expectStore(32'h204, 32'd4 + 32'd4, "jal link");
        expectNoMoreStores("jal");
    endtask

    task automatic testX0Halt();
        int i;
        prog.delete();
        prog.push_back(opImm(3'b000, 1, 0, 9));
        prog.push_back(opImm(3'b000, 0, 0, 32'h55));
        prog.push_back(lui(0, 32'h12345));
        prog.push_back(opReg(7'h00, 3'b000, 0, 1, 1));
        prog.push_back(sw(0, 0, 32'h200));
        prog.push_back(opReg(7'h00, 3'b000, 2, 0, 1));
        prog.push_back(sw(2, 0, 32'h204));
        prog.push_back(ebreakWord);
        runProgram(500);
        expectStore(32'h200, 32'd0, "x0 after writes");
        expectStore(32'h204, 32'd9, "x0 as operand");
        for (i = 0; i < 50; i++) begin
            @(negedge clk);
            check(32'(halted), 32'd1, "halted after ebreak");
        end
        expectNoMoreStores("halt window");
    endtask

    task automatic testRandom();
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] rnd;
        int          k;
        int          a;
        int          b;
        logic        isXor;
        seed = 32'hf21b;
        prog.delete();
        for (k = 1; k <= 4; k++) begin
            hi = $random(seed);
            lo = $random(seed);
            prog.push_back(lui(k, hi));
            prog.push_back(opImm(3'b000, k, k, lo));
            val[k] = {hi[19:0], 12'h000} + {{20{lo[11]}}, lo[11:0]};
        end
        for (k = 5; k <= 10; k++) begin
            rnd = $random(seed);
            a = 1 + rnd % (k - 1);
            rnd = $random(seed);
            b = 1 + rnd % (k - 1);
            rnd = $random(seed);
            isXor = rnd[0];
            prog.push_back(opReg(7'h00, isXor ? 3'b100 : 3'b000, k, a, b));
            val[k] = isXor ? (val[a] ^ val[b]) : (val[a] + val[b]);
        end
        for (k = 1; k <= 10; k++) begin
            prog.push_back(sw(k, 0, 32'h200 + 4 * k));
        end
        prog.push_back(ebreakWord);
        runProgram(1000);
        for (k = 1; k <= 10; k++) begin
            expectStore(32'h200 + 4 * k, val[k], $sformatf("random x%0d", k));
        end
        expectNoMoreStores("random");
    endtask

    initial begin
        arstN    = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        errors   = 0;
        checks   = 0;
        testArith();
        testLoadStore();
        testBranches();
        testJal();
        testX0Halt();
        testRandom();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: multiCycleCpu.f
source/rvPkg.sv
source/unifiedMemory.sv
source/regFile.sv
source/alu.sv
source/controlFsm.sv
source/datapath.sv
source/multiCycleCpu.sv
sim/multiCycleCpuTb.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f multiCycleCpu.f \
		--top-module multiCycleCpuTb --Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
